// File: mips.f
+incdir+rtl
rtl/mips_decls_p.sv
rtl/alu.sv
rtl/regfile.sv
rtl/datapath.sv
rtl/controller.sv
rtl/mips.sv
dv/mips_asserts.sv
dv/mips_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := mips_tb
FILELIST := mips.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

// File: dv/mips_tb.sv
`include "mips_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module mips_tb;

   // instruction encodings used by the program generator and the model
   localparam logic [5:0] OPC_RTYPE = 6'h00;
   localparam logic [5:0] OPC_J     = 6'h02;
   localparam logic [5:0] OPC_BEQ   = 6'h04;
   localparam logic [5:0] OPC_ADDI  = 6'h08;
   localparam logic [5:0] OPC_LW    = 6'h23;
   localparam logic [5:0] OPC_SW    = 6'h2b;
   localparam logic [5:0] FN_ADD    = 6'h20;
   localparam logic [5:0] FN_SUB    = 6'h22;
   localparam logic [5:0] FN_AND    = 6'h24;
   localparam logic [5:0] FN_OR     = 6'h25;
   localparam logic [5:0] FN_SLT    = 6'h2a;

   localparam int CLK_HALF     = 20;
   localparam int RESET_CYCLES = 5;
   localparam int NUM_RANDOM   = 40;
   // 7 register loads come first, then the random block, then the dump
   localparam int DUMP_START   = 7 + NUM_RANDOM;
   localparam int PROG_LEN     = DUMP_START + 8;

   logic               clk;
   logic               rst;
   logic [`MIPS_W-1:0] adr;
   logic [`MIPS_W-1:0] writedata;
   logic [`MIPS_W-1:0] readdata;
   logic               memwrite;

   logic [31:0] mem [256];
   logic [31:0] prog [PROG_LEN];
   logic [31:0] ref_mem [256];
   logic [31:0] ref_reg [32];
   logic [31:0] rng;
   logic        prog_ready;

   // store lists, expected from the model and seen on the bus
   logic [31:0] exp_addr [$];
   logic [31:0] exp_data [$];
   logic [31:0] act_addr [$];
   logic [31:0] act_data [$];
   int          act_cycle [$];
   int          exp_dump_cycle;
   int          exp_dump_idx;
   int          exp_total_cycles;
   int          cycle_cnt;
   logic        wr_pend;
   logic [7:0]  wr_idx;
   logic [31:0] wr_data;
   int          errors;
   int          checks;

   mips i_dut (
      .clk       (clk),
      .rst       (rst),
      .adr       (adr),
      .writedata (writedata),
      .memwrite  (memwrite),
      .readdata  (readdata)
   );

   // ------------------------------------------------------------------------
   // clock, cycle count and memory model
   // ------------------------------------------------------------------------
   initial clk = 1'b0;
   always #(CLK_HALF) clk = ~clk;

   // cycle n after reset sees cycle_cnt == n-1
   always @(posedge clk) begin
      if (rst)
         cycle_cnt <= 0;
      else
         cycle_cnt <= cycle_cnt + 1;
   end

   // word memory with combinational read
   assign readdata = mem[adr[9:2]];

   // store seen mid-cycle, committed on the closing rising edge
   always @(negedge clk) begin
      wr_pend <= memwrite;
      if (memwrite) begin
         wr_idx  <= adr[9:2];
         wr_data <= writedata;
         act_addr.push_back(adr);
         act_data.push_back(writedata);
         act_cycle.push_back(cycle_cnt + 1);
      end
   end

   initial begin : memory_model
      wait (prog_ready);
      for (int i = 0; i < 256; i++)
         mem[i] <= (i < PROG_LEN) ? prog[i] : fill_word(i);
      forever begin
         @(posedge clk);
         if (wr_pend)
            mem[wr_idx] <= wr_data;
      end
   end

   // ------------------------------------------------------------------------
   // random numbers and instruction encoding
   // ------------------------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic int unsigned pick(input int unsigned n);
      rng = xorshift32(rng);
      return rng % n;
   endfunction

   // data region contents before the run, every address bit mixed in
   function automatic logic [31:0] fill_word(input int i);
      return (32'(i) * 32'h9e37_79b1) ^ 32'hc001_0000;
   endfunction

   function automatic logic [31:0] rtype_word(input int rs, input int rt, input int rd,
                                              input logic [5:0] fn);
      return {OPC_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
   endfunction

   function automatic logic [31:0] itype_word(input logic [5:0] op, input int rs,
                                              input int rt, input logic [15:0] imm);
      return {op, 5'(rs), 5'(rt), imm};
   endfunction

   function automatic logic [31:0] jump_word(input int target);
      return {OPC_J, 26'(target)};
   endfunction

   task automatic build_program();
      int idx;
      int room;
      int skip;
      int rs;
      logic [5:0] fn;
      for (int r = 1; r < 8; r++)
         prog[r-1] = itype_word(OPC_ADDI, 0, r, 16'(pick(65536)));
      for (int k = 0; k < NUM_RANDOM; k++) begin
         idx  = 7 + k;
         room = NUM_RANDOM - 1 - k;
         // forward only, never past the start of the dump
         skip = int'(pick(32'((room < 3 ? room : 3) + 1)));
         rs   = int'(pick(8));
         case (pick(10))
            0, 1, 2, 3: begin
               case (pick(5))
                  0:       fn = FN_ADD;
                  1:       fn = FN_SUB;
                  2:       fn = FN_AND;
                  3:       fn = FN_OR;
                  default: fn = FN_SLT;
               endcase
               prog[idx] = rtype_word(rs, int'(pick(8)), int'(pick(8)), fn);
            end
            4, 9: prog[idx] = itype_word(OPC_ADDI, rs, int'(pick(8)), 16'(pick(65536)));
            // base is $0 so the offset alone lands in words 128 to 191
            5: prog[idx] = itype_word(OPC_LW, 0, int'(pick(8)), 16'((128 + pick(64)) * 4));
            6: prog[idx] = itype_word(OPC_SW, 0, int'(pick(8)), 16'((128 + pick(64)) * 4));
            // same register half the time so that some branches are taken
            7: prog[idx] = itype_word(OPC_BEQ, rs, (pick(2) == 0) ? rs : int'(pick(8)),
                                      16'(skip));
            default: prog[idx] = jump_word(idx + 1 + skip);
         endcase
      end
      for (int r = 1; r < 8; r++)
         prog[DUMP_START+r-1] = itype_word(OPC_SW, 0, r, 16'((199 + r) * 4));
      prog[DUMP_START+7] = jump_word(DUMP_START + 7);
   endtask

   // ------------------------------------------------------------------------
   // instruction-set model
   // ------------------------------------------------------------------------
   task automatic run_model();
      int          pc_idx;
      int          cycles;
      int          rs;
      int          rt;
      int          rd;
      logic [31:0] ins;
      logic [31:0] simm;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [31:0] addr;
      for (int i = 0; i < 256; i++)
         ref_mem[i] = (i < PROG_LEN) ? prog[i] : fill_word(i);
      for (int i = 0; i < 32; i++)
         ref_reg[i] = '0;
      pc_idx = 0;
      cycles = 0;
      exp_dump_cycle = -1;
      for (int step = 0; step < 1000; step++) begin
         // the first dump store writes in its fourth cycle
         if (pc_idx == DUMP_START && exp_dump_cycle < 0) begin
            exp_dump_cycle = cycles + 4;
            exp_dump_idx   = exp_addr.size();
         end
         ins  = ref_mem[pc_idx];
         rs   = int'(ins[25:21]);
         rt   = int'(ins[20:16]);
         rd   = int'(ins[15:11]);
         simm = {{16{ins[15]}}, ins[15:0]};
         a    = ref_reg[rs];
         b    = ref_reg[rt];
         addr = a + simm;
         // a jump to itself ends the program
         if (ins[31:26] == OPC_J && int'(ins[25:0]) == pc_idx)
            break;
         case (ins[31:26])
            OPC_RTYPE: begin
               case (ins[5:0])
                  FN_ADD:  res = a + b;
                  FN_SUB:  res = a - b;
                  FN_AND:  res = a & b;
                  FN_OR:   res = a | b;
                  default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               endcase
               if (rd != 0)
                  ref_reg[rd] = res;
               cycles += 4;
               pc_idx += 1;
            end
            OPC_ADDI: begin
               if (rt != 0)
                  ref_reg[rt] = addr;
               cycles += 4;
               pc_idx += 1;
            end
            OPC_LW: begin
               if (rt != 0)
                  ref_reg[rt] = ref_mem[addr[9:2]];
               cycles += 5;
               pc_idx += 1;
            end
            OPC_SW: begin
               exp_addr.push_back(addr);
               exp_data.push_back(b);
               ref_mem[addr[9:2]] = b;
               cycles += 4;
               pc_idx += 1;
            end
            OPC_BEQ: begin
               pc_idx = (a == b) ? pc_idx + 1 + int'(signed'(ins[15:0])) : pc_idx + 1;
               cycles += 3;
            end
            default: begin
               pc_idx = int'(ins[25:0]);
               cycles += 3;
            end
         endcase
      end
      // count the closing jump once
      exp_total_cycles = cycles + 3;
   endtask

   task automatic compare(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("mismatch %s expected %h actual %h", name, expected, actual);
      end
   endtask

   // ------------------------------------------------------------------------
   // watchdog
   // ------------------------------------------------------------------------
   initial begin : watchdog
      wait (prog_ready);
      #((4 * exp_total_cycles + RESET_CYCLES) * 2 * CLK_HALF);
      $display("timeout: the processor did not finish the program in %0d cycles",
               4 * exp_total_cycles);
      $display("Simulation failed");
      $finish;
   end

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial begin
      rst        = 1'b1;
      errors     = 0;
      checks     = 0;
      rng        = 32'd98;
      prog_ready = 1'b0;
      build_program();
      run_model();
      prog_ready = 1'b1;

      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;
      // first cycle after reset fetches from the reset pc
      compare("reset adr", 32'(`RESET_PC), adr);
      compare("reset memwrite", 32'd0, 32'(memwrite));

      while (act_addr.size() < exp_addr.size())
         @(negedge clk);
      // a quiet tail shows the self jump does not store
      repeat (20) @(negedge clk);

      compare("store count", 32'(exp_addr.size()), 32'(act_addr.size()));
      for (int i = 0; i < exp_addr.size(); i++) begin
         if (i < act_addr.size()) begin
            compare($sformatf("store %0d address", i), exp_addr[i], act_addr[i]);
            compare($sformatf("store %0d data", i), exp_data[i], act_data[i]);
         end
      end
      if (exp_dump_idx < act_cycle.size())
         compare("first dump store cycle", 32'(exp_dump_cycle), 32'(act_cycle[exp_dump_idx]));
      // register dump in words 200 to 206
      for (int i = 200; i < 207; i++)
         compare($sformatf("dump word %0d", i), ref_mem[i], mem[i]);
      errors += i_dut.u_controller.i_asserts.fail_count;

      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: dv/mips_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mips_asserts (
   input logic                  clk,
   input logic                  rst,
   input mips_decls_p::state_t  state,
   input logic                  memwrite,
   input logic                  irwrite,
   input logic                  regwrite
);
   import mips_decls_p::*;

   // failures seen so far, read by the testbench at the end
   int fail_count = 0;

   // ------------------------------------------------------------------------
   // controller and memory port properties
   // ------------------------------------------------------------------------

   // stores only come from the memory write state
   store_in_memwr: assert property (@(posedge clk) disable iff (rst)
      memwrite |-> (state == S_MEMWR))
      else begin
         fail_count++;
         $error("memwrite high outside S_MEMWR");
      end

   // instruction register loads only in fetch
   irwrite_in_fetch: assert property (@(posedge clk) disable iff (rst)
      irwrite |-> (state == S_FETCH))
      else begin
         fail_count++;
         $error("irwrite high outside S_FETCH");
      end

   // reset leaves the controller in fetch
   reset_to_fetch: assert property (@(posedge clk) rst |=> (state == S_FETCH))
      else begin
         fail_count++;
         $error("state is not S_FETCH after reset");
      end

   // a register write and a store never share a cycle
   no_write_overlap: assert property (@(posedge clk) disable iff (rst)
      !(regwrite && memwrite))
      else begin
         fail_count++;
         $error("regwrite and memwrite high together");
      end

endmodule

bind controller mips_asserts i_asserts (
   .clk      (clk),
   .rst      (rst),
   .state    (state),
   .memwrite (memwrite),
   .irwrite  (irwrite),
   .regwrite (regwrite)
);

`default_nettype wire

// File: rtl/mips.sv
`include "mips_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module mips (
   input  logic               clk,
   input  logic               rst,
   output logic [`MIPS_W-1:0] adr,
   output logic [`MIPS_W-1:0] writedata,
   output logic               memwrite,
   input  logic [`MIPS_W-1:0] readdata
);
   import mips_decls_p::*;

   // controller to datapath
   logic       pcen;
   logic       irwrite;
   logic       regwrite;
   logic       alusrca;
   logic       iord;
   logic       memtoreg;
   logic       regdst;
   logic [1:0] alusrcb;
   logic [1:0] pcsrc;
   alu_op_t    alucontrol;
   // datapath to controller
   opcode_t    opcode;
   funct_t     funct;
   logic       zero;

   controller u_controller (
      .clk        (clk),
      .rst        (rst),
      .opcode     (opcode),
      .funct      (funct),
      .zero       (zero),
      .pcen       (pcen),
      .irwrite    (irwrite),
      .regwrite   (regwrite),
      .memwrite   (memwrite),
      .alusrca    (alusrca),
      .iord       (iord),
      .memtoreg   (memtoreg),
      .regdst     (regdst),
      .alusrcb    (alusrcb),
      .pcsrc      (pcsrc),
      .alucontrol (alucontrol)
   );

   datapath u_datapath (
      .clk        (clk),
      .rst        (rst),
      .pcen       (pcen),
      .irwrite    (irwrite),
      .regwrite   (regwrite),
      .alusrca    (alusrca),
      .iord       (iord),
      .memtoreg   (memtoreg),
      .regdst     (regdst),
      .alusrcb    (alusrcb),
      .pcsrc      (pcsrc),
      .alucontrol (alucontrol),
      .opcode     (opcode),
      .funct      (funct),
      .zero       (zero),
      .adr        (adr),
      .writedata  (writedata),
      .readdata   (readdata)
   );

endmodule

`default_nettype wire

// File: rtl/controller.sv
`timescale 1ns/1ps
`default_nettype none

module controller (
   input  logic                  clk,
   input  logic                  rst,
   input  mips_decls_p::opcode_t opcode,
   input  mips_decls_p::funct_t  funct,
   input  logic                  zero,
   output logic                  pcen,
   output logic                  irwrite,
   output logic                  regwrite,
   output logic                  memwrite,
   output logic                  alusrca,
   output logic                  iord,
   output logic                  memtoreg,
   output logic                  regdst,
   output logic [1:0]            alusrcb,
   output logic [1:0]            pcsrc,
   output mips_decls_p::alu_op_t alucontrol
);
   import mips_decls_p::*;

   state_t  state;
   state_t  state_next;
   logic    pcwrite;
   logic    branch;
   alu_op_t funct_op;

   //--------------------------------------------------------------------------
   // state register and sequencing
   //--------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst)
         state <= S_FETCH;
      else
         state <= state_next;
   end

   always_comb begin
      case (state)
         S_FETCH:  state_next = S_DECODE;
         // dispatch on the opcode, unknown ones restart fetch
         S_DECODE: begin
            case (opcode)
               OP_LW,
               OP_SW:    state_next = S_MEMADR;
               OP_RTYPE: state_next = S_EXECUTE;
               OP_BEQ:   state_next = S_BRANCH;
               OP_ADDI:  state_next = S_ADDIEX;
               OP_J:     state_next = S_JUMP;
               default:  state_next = S_FETCH;
            endcase
         end
         S_MEMADR: state_next = (opcode == OP_LW) ? S_MEMRD :
                                (opcode == OP_SW) ? S_MEMWR : S_FETCH;
         S_MEMRD:   state_next = S_MEMWB;
         S_EXECUTE: state_next = S_ALUWB;
         S_ADDIEX:  state_next = S_ADDIWB;
         // memwb, memwr, aluwb, branch, addiwb and jump all end here
         default:   state_next = S_FETCH;
      endcase
   end

   //--------------------------------------------------------------------------
   // alu decoder for r-type
   //--------------------------------------------------------------------------
   always_comb begin
      case (funct)
         F_SUB:   funct_op = ALU_SUB;
         F_AND:   funct_op = ALU_AND;
         F_OR:    funct_op = ALU_OR;
         F_SLT:   funct_op = ALU_SLT;
         default: funct_op = ALU_ADD;
      endcase
   end

   //--------------------------------------------------------------------------
   // output decode
   //--------------------------------------------------------------------------
   always_comb begin
      // idle values, alu adds pc and b
      pcwrite    = 1'b0;
      branch     = 1'b0;
      irwrite    = 1'b0;
      regwrite   = 1'b0;
      memwrite   = 1'b0;
      alusrca    = 1'b0;
      iord       = 1'b0;
      memtoreg   = 1'b0;
      regdst     = 1'b0;
      alusrcb    = 2'b00;
      pcsrc      = 2'b00;
      alucontrol = ALU_ADD;
      case (state)
         // load ir and step pc by 4
         S_FETCH: begin
            irwrite = 1'b1;
            pcwrite = 1'b1;
            alusrcb = 2'b01;
         end
         // precompute branch target into aluout
         S_DECODE: alusrcb = 2'b11;
         S_MEMADR, S_ADDIEX: begin
            alusrca = 1'b1;
            alusrcb = 2'b10;
         end
         S_MEMRD: iord = 1'b1;
         S_MEMWB: begin
            regwrite = 1'b1;
            memtoreg = 1'b1;
         end
         S_MEMWR: begin
            iord     = 1'b1;
            memwrite = 1'b1;
         end
         S_EXECUTE: begin
            alusrca    = 1'b1;
            alucontrol = funct_op;
         end
         S_ALUWB: begin
            regwrite = 1'b1;
            regdst   = 1'b1;
         end
         // compare a and b, take target from aluout
         S_BRANCH: begin
            alusrca    = 1'b1;
            alucontrol = ALU_SUB;
            pcsrc      = 2'b01;
            branch     = 1'b1;
         end
         S_ADDIWB: regwrite = 1'b1;
         S_JUMP: begin
            pcwrite = 1'b1;
            pcsrc   = 2'b10;
         end
         default: ;
      endcase
   end

   // pc loads unconditionally or on a taken beq
   assign pcen = pcwrite | (branch & zero);

endmodule

`default_nettype wire

// File: rtl/datapath.sv
`include "mips_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module datapath (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  pcen,
   input  logic                  irwrite,
   input  logic                  regwrite,
   input  logic                  alusrca,
   input  logic                  iord,
   input  logic                  memtoreg,
   input  logic                  regdst,
   input  logic [1:0]            alusrcb,
   input  logic [1:0]            pcsrc,
   input  mips_decls_p::alu_op_t alucontrol,
   output mips_decls_p::opcode_t opcode,
   output mips_decls_p::funct_t  funct,
   output logic                  zero,
   output logic [`MIPS_W-1:0]    adr,
   output logic [`MIPS_W-1:0]    writedata,
   input  logic [`MIPS_W-1:0]    readdata
);
   import mips_decls_p::*;

   // architectural and intermediate registers
   logic [`MIPS_W-1:0] pc;
   logic [`MIPS_W-1:0] instr;
   logic [`MIPS_W-1:0] data;
   logic [`MIPS_W-1:0] a_reg;
   logic [`MIPS_W-1:0] b_reg;
   logic [`MIPS_W-1:0] aluout;
   // combinational nets
   logic [`MIPS_W-1:0] pcnext;
   logic [`MIPS_W-1:0] rd1;
   logic [`MIPS_W-1:0] rd2;
   logic [`MIPS_W-1:0] regresult;
   logic [`MIPS_W-1:0] srca;
   logic [`MIPS_W-1:0] srcb;
   logic [`MIPS_W-1:0] aluresult;
   logic [`MIPS_W-1:0] signimm;
   logic [`MIPS_W-1:0] pcjump;
   logic [`REG_AW-1:0] writereg;

   //--------------------------------------------------------------------------
   // instruction fields
   //--------------------------------------------------------------------------
   assign opcode    = opcode_t'(instr[31:26]);
   assign funct     = funct_t'(instr[5:0]);
   assign signimm   = {{(`MIPS_W-16){instr[15]}}, instr[15:0]};
   // pseudo-direct target keeps the upper pc nibble
   assign pcjump    = {pc[`MIPS_W-1:28], instr[25:0], 2'b00};
   assign writedata = b_reg;

   //--------------------------------------------------------------------------
   // registers
   //--------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         pc    <= `MIPS_W'(`RESET_PC);
         instr <= '0;
      end else begin
         if (pcen)
            pc <= pcnext;
         // ir only loads in fetch
         if (irwrite)
            instr <= readdata;
      end
   end

   // these capture every cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         data   <= '0;
         a_reg  <= '0;
         b_reg  <= '0;
         aluout <= '0;
      end else begin
         data   <= readdata;
         a_reg  <= rd1;
         b_reg  <= rd2;
         aluout <= aluresult;
      end
   end

   //--------------------------------------------------------------------------
   // selects, register file and alu
   //--------------------------------------------------------------------------
   assign adr       = iord ? aluout : pc;
   assign writereg  = regdst ? instr[15:11] : instr[20:16];
   assign regresult = memtoreg ? data : aluout;
   assign srca      = alusrca ? a_reg : pc;

   always_comb begin
      case (alusrcb)
         2'b00:   srcb = b_reg;
         2'b01:   srcb = `MIPS_W'(`PC_INC);
         2'b10:   srcb = signimm;
         default: srcb = {signimm[`MIPS_W-3:0], 2'b00};   // branch offset
      endcase
   end

   // next pc is pc+4, branch target held in aluout, or jump target
   always_comb begin
      case (pcsrc)
         2'b01:   pcnext = aluout;
         2'b10:   pcnext = pcjump;
         default: pcnext = aluresult;
      endcase
   end

   regfile u_rf (
      .clk (clk),
      .we  (regwrite),
      .ra1 (instr[25:21]),
      .ra2 (instr[20:16]),
      .wa  (writereg),
      .wd  (regresult),
      .rd1 (rd1),
      .rd2 (rd2)
   );

   alu u_alu (
      .a    (srca),
      .b    (srcb),
      .f    (alucontrol),
      .y    (aluresult),
      .zero (zero)
   );

endmodule

`default_nettype wire

// File: rtl/regfile.sv
`include "mips_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module regfile (
   input  logic               clk,
   input  logic               we,
   input  logic [`REG_AW-1:0] ra1,
   input  logic [`REG_AW-1:0] ra2,
   input  logic [`REG_AW-1:0] wa,
   input  logic [`MIPS_W-1:0] wd,
   output logic [`MIPS_W-1:0] rd1,
   output logic [`MIPS_W-1:0] rd2
);

   logic [`MIPS_W-1:0] regs [2**`REG_AW];

   // write on the rising edge, $0 is hardwired
   always_ff @(posedge clk) begin
      if (we && (wa != '0))
         regs[wa] <= wd;
   end

   // two asynchronous read ports
   assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
   assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// File: rtl/alu.sv
`include "mips_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  logic [`MIPS_W-1:0]    a,
   input  logic [`MIPS_W-1:0]    b,
   input  mips_decls_p::alu_op_t f,
   output logic [`MIPS_W-1:0]    y,
   output logic                  zero
);
   import mips_decls_p::*;

   // purely combinational, result settles within the state
   always_comb begin
      case (f)
         ALU_AND: y = a & b;
         ALU_OR:  y = a | b;
         ALU_ADD: y = a + b;
         ALU_SUB: y = a - b;
         // signed compare gives 1 or 0 in the low bit
         ALU_SLT: y = ($signed(a) < $signed(b)) ? `MIPS_W'(1) : '0;
         default: y = '0;
      endcase
   end

   // beq tests this after the subtract
   assign zero = (y == '0);

endmodule

`default_nettype wire

// File: rtl/mips_decls_p.sv
`default_nettype none

package mips_decls_p;

   //--------------------------------------------------------------------------
   // instruction encodings
   //--------------------------------------------------------------------------

   // primary opcode field in instr[31:26]
   typedef enum logic [5:0] {
      OP_RTYPE = 6'b000000,
      OP_J     = 6'b000010,
      OP_BEQ   = 6'b000100,
      OP_ADDI  = 6'b001000,
      OP_LW    = 6'b100011,
      OP_SW    = 6'b101011
   } opcode_t;

   // r-type function field in instr[5:0]
   typedef enum logic [5:0] {
      F_ADD = 6'b100000,
      F_SUB = 6'b100010,
      F_AND = 6'b100100,
      F_OR  = 6'b100101,
      F_SLT = 6'b101010
   } funct_t;

   //--------------------------------------------------------------------------
   // control encodings
   //--------------------------------------------------------------------------

   // alu function select
   typedef enum logic [2:0] {
      ALU_AND = 3'b000,
      ALU_OR  = 3'b001,
      ALU_ADD = 3'b010,
      ALU_SUB = 3'b110,
      ALU_SLT = 3'b111
   } alu_op_t;

   // multicycle controller states, each held for one clock
   typedef enum logic [3:0] {
      S_FETCH,
      S_DECODE,
      S_MEMADR,
      S_MEMRD,
      S_MEMWB,
      S_MEMWR,
      S_EXECUTE,
      S_ALUWB,
      S_BRANCH,
      S_ADDIEX,
      S_ADDIWB,
      S_JUMP
   } state_t;

endpackage

`default_nettype wire

// File: rtl/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// data word and byte address width
`define MIPS_W 32

// register number width for the 32 entry register file
`define REG_AW 5

// program counter value loaded on reset
`define RESET_PC 0

// byte step from one instruction word to the next
`define PC_INC 4

`endif
